// ==== rtl/pcie_desc_pkg.sv ====
package pcie_desc_pkg;

    // byte address on the host side of the link
    typedef logic [63:0] host_addr_t;

    // transfer length in dwords, as the write data mover counts it
    typedef logic [17:0] dword_cnt_t;

    typedef logic [7:0] desc_id_t;

    // write data mover descriptor of 174 bits with the most significant field first
    typedef struct packed {
        logic [7:0]  func_nb;
        desc_id_t    desc_id;
        logic [7:0]  app_spec;
        logic [1:0]  reserved;
        logic        single_src;
        // saddr_data carries the payload itself
        logic        immediate;
        dword_cnt_t  nb_dwords;
        host_addr_t  dst_addr;
        // source address in the endpoint, or immediate data
        logic [63:0] saddr_data;
    } wrdm_desc_t;

    // endpoint BAR offset where the mover fetches payload
    localparam host_addr_t EP_BASE_ADDR = 64'h0000_0000_0004_0000;

    // marks the pointer write-back descriptor
    localparam desc_id_t DONE_ID = 8'hFE;

    // first 64 bytes of the host buffer hold the done word
    // and payload lands above it
    localparam host_addr_t DATA_OFFSET = 64'd64;

endpackage

// ==== rtl/prof_regs_pkg.sv ====
package prof_regs_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [31:0] count_t;

    localparam apb_addr_t REG_CTRL      = 8'h00;
    localparam apb_addr_t REG_TARGET    = 8'h04;
    localparam apb_addr_t REG_REQ_SIZE  = 8'h08;
    localparam apb_addr_t REG_KMEM_LO   = 8'h0C;
    localparam apb_addr_t REG_KMEM_HI   = 8'h10;
    localparam apb_addr_t REG_STATUS    = 8'h14;
    localparam apb_addr_t REG_NB_REQ    = 8'h18;
    localparam apb_addr_t REG_TX_CYCLES = 8'h1C;
    localparam apb_addr_t REG_STALL_CNT = 8'h20;

    // CTRL bit positions
    localparam int CTRL_START         = 0;
    localparam int CTRL_WRITE_POINTER = 1;
    localparam int CTRL_USE_BRAM      = 2;

    typedef struct packed {
        logic                      write_pointer;
        logic                      use_bram;
        count_t                    target_nb_requests;
        pcie_desc_pkg::dword_cnt_t req_size;
        pcie_desc_pkg::host_addr_t kmem_addr;
    } prof_cfg_t;

    typedef struct packed {
        logic   busy;
        count_t nb_requests;
        count_t transmit_cycles;
        count_t stall_cnt;
    } prof_stat_t;

endpackage

// ==== rtl/prof_apb_regs.sv ====
`timescale 1ns/1ps

module prof_apb_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  prof_regs_pkg::apb_addr_t  paddr,
    input  prof_regs_pkg::apb_data_t  pwdata,
    output prof_regs_pkg::apb_data_t  prdata,
    output logic                      pready,
    output logic                      pslverr,
    output prof_regs_pkg::prof_cfg_t  cfg,
    output logic                      start,
    input  prof_regs_pkg::prof_stat_t stat
);

    import prof_regs_pkg::*;

    logic      access;
    logic      mapped;
    logic      writable;
    logic      wr_en;
    apb_data_t rd_mux;

    // access phase always completes in one cycle
    assign pready = 1'b1;
    assign access = psel && penable;

    always_comb begin
        mapped   = 1'b1;
        writable = 1'b0;
        rd_mux   = '0;
        case (paddr)
            REG_CTRL: begin
                writable = 1'b1;
                // start is a pulse and reads back as zero
                rd_mux = apb_data_t'({cfg.use_bram, cfg.write_pointer, 1'b0});
            end
            REG_TARGET: begin
                writable = 1'b1;
                rd_mux   = cfg.target_nb_requests;
            end
            REG_REQ_SIZE: begin
                writable = 1'b1;
                rd_mux   = apb_data_t'(cfg.req_size);
            end
            REG_KMEM_LO: begin
                writable = 1'b1;
                rd_mux   = cfg.kmem_addr[31:0];
            end
            REG_KMEM_HI: begin
                writable = 1'b1;
                rd_mux   = cfg.kmem_addr[63:32];
            end
            REG_STATUS:    rd_mux = apb_data_t'(stat.busy);
            REG_NB_REQ:    rd_mux = stat.nb_requests;
            REG_TX_CYCLES: rd_mux = stat.transmit_cycles;
            REG_STALL_CNT: rd_mux = stat.stall_cnt;
            default:       mapped = 1'b0;
        endcase
    end

    assign prdata  = (access && !pwrite) ? rd_mux : '0;
    assign pslverr = access && (!mapped || (pwrite && !writable));
    assign wr_en   = access && pwrite && writable;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            start <= wr_en && (paddr == REG_CTRL) && pwdata[CTRL_START];
            if (wr_en) begin
                case (paddr)
                    REG_CTRL: begin
                        cfg.write_pointer <= pwdata[CTRL_WRITE_POINTER];
                        cfg.use_bram      <= pwdata[CTRL_USE_BRAM];
                    end
                    REG_TARGET:   cfg.target_nb_requests <= pwdata;
                    REG_REQ_SIZE: cfg.req_size <= pwdata[$bits(cfg.req_size)-1:0];
                    REG_KMEM_LO:  cfg.kmem_addr[31:0] <= pwdata;
                    REG_KMEM_HI:  cfg.kmem_addr[63:32] <= pwdata;
                    default: ;
                endcase
            end
        end
    end

    // bus master must hold psel through the access phase
    penable_needs_psel: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    ) else $error("apb penable high without psel");

endmodule

// ==== rtl/desc_issuer.sv ====
`timescale 1ns/1ps

module desc_issuer (
    input  logic                      clk,
    input  logic                      rst,
    input  prof_regs_pkg::prof_cfg_t  cfg,
    input  logic                      start,
    input  logic                      wrdm_desc_ready,
    output logic                      wrdm_desc_valid,
    output pcie_desc_pkg::wrdm_desc_t wrdm_desc_data,
    output prof_regs_pkg::prof_stat_t stat
);

    import pcie_desc_pkg::*;
    import prof_regs_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        DONE
    } state_t;

    state_t     state;
    logic       ready_r1;
    logic       ready_r2;
    logic       dma_ctrl_ready;
    logic       desc_valid;
    logic       pending_transfer;
    logic       ready_for_new;
    logic       busy;
    logic       last_data;
    count_t     nb_requests;
    count_t     transmit_cycles;
    count_t     stall_cnt;
    wrdm_desc_t data_desc;
    wrdm_desc_t done_desc;

    assign data_desc = '{
        func_nb:    '0,
        desc_id:    '0,
        app_spec:   '0,
        reserved:   '0,
        single_src: 1'b0,
        immediate:  1'b0,
        nb_dwords:  cfg.req_size,
        dst_addr:   cfg.kmem_addr + DATA_OFFSET,
        saddr_data: EP_BASE_ADDR
    };

    // immediate write of the running count to the host base address
    assign done_desc = '{
        func_nb:    '0,
        desc_id:    DONE_ID,
        app_spec:   '0,
        reserved:   '0,
        single_src: 1'b0,
        immediate:  1'b1,
        nb_dwords:  dword_cnt_t'(1),
        dst_addr:   cfg.kmem_addr,
        saddr_data: 64'(nb_requests)
    };

    // mover reports readiness three cycles late, so trust it only after
    // three high cycles in a row
    assign dma_ctrl_ready = wrdm_desc_ready && ready_r2;

    // valid can never be seen while ready is low
    assign wrdm_desc_valid = desc_valid && wrdm_desc_ready;

    // a dropped send has to go out again before anything new
    assign ready_for_new = dma_ctrl_ready && !pending_transfer;

    assign last_data = (nb_requests + count_t'(1)) == cfg.target_nb_requests;
    assign busy      = (state != IDLE) || desc_valid || pending_transfer;

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= IDLE;
            ready_r1         <= 1'b0;
            ready_r2         <= 1'b0;
            desc_valid       <= 1'b0;
            pending_transfer <= 1'b0;
            nb_requests      <= '0;
            transmit_cycles  <= '0;
            stall_cnt        <= '0;
        end else begin
            ready_r1   <= wrdm_desc_ready;
            ready_r2   <= ready_r1 && wrdm_desc_ready;
            desc_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (start && !busy && (cfg.target_nb_requests != '0)) begin
                        nb_requests     <= '0;
                        transmit_cycles <= '0;
                        stall_cnt       <= '0;
                        state           <= DATA;
                    end
                end
                DATA: begin
                    if (ready_for_new) begin
                        desc_valid  <= 1'b1;
                        nb_requests <= nb_requests + count_t'(1);
                        if (cfg.write_pointer) begin
                            state <= DONE;
                        end else if (last_data) begin
                            state <= IDLE;
                        end
                    end
                end
                DONE: begin
                    // count was already bumped by the data send
                    if (ready_for_new) begin
                        desc_valid <= 1'b1;
                        if (nb_requests == cfg.target_nb_requests) begin
                            state <= IDLE;
                        end else begin
                            state <= DATA;
                        end
                    end
                end
                default: state <= IDLE;
            endcase

            if (desc_valid && !wrdm_desc_ready) begin
                pending_transfer <= 1'b1;
            end
            // descriptor register still holds the dropped one
            if (dma_ctrl_ready && pending_transfer) begin
                desc_valid       <= 1'b1;
                pending_transfer <= 1'b0;
            end

            if (state != IDLE) begin
                transmit_cycles <= transmit_cycles + count_t'(1);
                if (!dma_ctrl_ready) begin
                    stall_cnt <= stall_cnt + count_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready_for_new && (state == DATA)) begin
            wrdm_desc_data <= data_desc;
        end else if (ready_for_new && (state == DONE)) begin
            wrdm_desc_data <= done_desc;
        end
    end

    assign stat = '{
        busy:            busy,
        nb_requests:     nb_requests,
        transmit_cycles: transmit_cycles,
        stall_cnt:       stall_cnt
    };

    // every send rides on a ready window of at least four cycles
    valid_in_ready_window: assert property (
        @(posedge clk) disable iff (rst)
        wrdm_desc_valid |-> wrdm_desc_ready && $past(wrdm_desc_ready)
            && $past(wrdm_desc_ready, 2) && $past(wrdm_desc_ready, 3)
    ) else $error("descriptor sent outside a trusted ready window");

endmodule

// ==== rtl/pattern_buffer.sv ====
`timescale 1ns/1ps

module pattern_buffer #(
    parameter int BUF_AWIDTH = 6,
    parameter int BUF_DEPTH  = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  use_bram,
    input  logic                  frb_read,
    input  logic [BUF_AWIDTH-1:0] frb_address,
    output logic                  frb_readvalid,
    output logic [511:0]          frb_readdata
);

    localparam logic [63:0] FILL_WORD   = 64'h0000babe0000face;
    localparam logic [63:0] BYPASS_WORD = 64'hdead0000beef0000;

    logic [511:0]          mem [BUF_DEPTH];
    logic [BUF_AWIDTH-1:0] fill_addr;
    logic                  fill_active;
    logic [63:0]           fill_word;
    logic [511:0]          ram_q;
    logic                  read_r;

    // low address bits stamped into every 64-bit lane
    assign fill_word = {FILL_WORD[63:BUF_AWIDTH], fill_addr};

    // one entry per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_addr   <= '0;
            fill_active <= 1'b1;
        end else if (fill_active) begin
            fill_addr <= fill_addr + 1'b1;
            if (fill_addr == BUF_AWIDTH'(BUF_DEPTH - 1)) begin
                fill_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_active) begin
            mem[fill_addr] <= {8{fill_word}};
        end
        if (frb_read) begin
            ram_q <= mem[frb_address];
        end
    end

    // bram path takes two cycles, bypass takes one
    always_ff @(posedge clk) begin
        if (rst) begin
            read_r        <= 1'b0;
            frb_readvalid <= 1'b0;
        end else begin
            read_r        <= frb_read;
            frb_readvalid <= use_bram ? read_r : frb_read;
        end
    end

    always_ff @(posedge clk) begin
        frb_readdata <= use_bram ? ram_q : {8{BYPASS_WORD}};
    end

    read_addr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        frb_read |-> (int'(frb_address) < BUF_DEPTH)
    ) else $error("frb_address beyond pattern buffer depth");

endmodule

// ==== rtl/pcie_write_profiler.sv ====
`timescale 1ns/1ps

module pcie_write_profiler #(
    parameter int BUF_AWIDTH = 6,
    parameter int BUF_DEPTH  = 64
) (
    input  logic                      clk,
    input  logic                      rst,

    // apb slave
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  prof_regs_pkg::apb_addr_t  paddr,
    input  prof_regs_pkg::apb_data_t  pwdata,
    output prof_regs_pkg::apb_data_t  prdata,
    output logic                      pready,
    output logic                      pslverr,

    // descriptors to the write data mover
    input  logic                      wrdm_desc_ready,
    output logic                      wrdm_desc_valid,
    output pcie_desc_pkg::wrdm_desc_t wrdm_desc_data,

    // payload reads from the mover
    input  logic                      frb_read,
    input  logic [BUF_AWIDTH-1:0]     frb_address,
    output logic                      frb_readvalid,
    output logic [511:0]              frb_readdata
);

    import prof_regs_pkg::*;

    prof_cfg_t  cfg;
    prof_stat_t stat;
    logic       start;

    prof_apb_regs prof_apb_regs_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg),
        .start   (start),
        .stat    (stat)
    );

    desc_issuer desc_issuer_i (
        .clk             (clk),
        .rst             (rst),
        .cfg             (cfg),
        .start           (start),
        .wrdm_desc_ready (wrdm_desc_ready),
        .wrdm_desc_valid (wrdm_desc_valid),
        .wrdm_desc_data  (wrdm_desc_data),
        .stat            (stat)
    );

    pattern_buffer #(
        .BUF_AWIDTH (BUF_AWIDTH),
        .BUF_DEPTH  (BUF_DEPTH)
    ) pattern_buffer_i (
        .clk           (clk),
        .rst           (rst),
        .use_bram      (cfg.use_bram),
        .frb_read      (frb_read),
        .frb_address   (frb_address),
        .frb_readvalid (frb_readvalid),
        .frb_readdata  (frb_readdata)
    );

endmodule

// ==== test/tb_pcie_write_profiler.sv ====
`timescale 1ns/1ps

module tb_pcie_write_profiler;

    import pcie_desc_pkg::*;
    import prof_regs_pkg::*;

    localparam int BUF_AWIDTH     = 6;
    localparam int BUF_DEPTH      = 64;
    localparam int SEED           = 93906;
    localparam int RESTART_TARGET = 30;

    // descriptor and pattern values as the mover sees them
    localparam logic [63:0] EXP_EP_BASE  = 64'h0000_0000_0004_0000;
    localparam logic [7:0]  EXP_DONE_ID  = 8'hFE;
    localparam logic [63:0] EXP_DATA_OFS = 64'd64;
    localparam logic [63:0] FILL_WORD    = 64'h0000babe0000face;
    localparam logic [63:0] BYPASS_WORD  = 64'hdead0000beef0000;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    apb_addr_t             paddr;
    apb_data_t             pwdata;
    apb_data_t             prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  wrdm_desc_ready = 1'b1;
    logic                  wrdm_desc_valid;
    wrdm_desc_t            wrdm_desc_data;
    logic                  frb_read;
    logic [BUF_AWIDTH-1:0] frb_address;
    logic                  frb_readvalid;
    logic [511:0]          frb_readdata;

    logic [31:0]  rng_main;
    logic [31:0]  rng_ready;
    int           errors;
    int           errors_at_start;
    int           tests_run;
    int           tests_failing;
    int           cyc;
    int           cycle_limit;
    logic         ready_random;
    int           lo_left;
    int           hi_left;
    logic         in_run;
    int           accepted;
    int           exp_total;
    int           low_seen;
    int           rd_latency;
    wrdm_desc_t   exp_q[$];
    wrdm_desc_t   exp_d;
    int           rd_due[$];
    logic [511:0] rd_data[$];

    pcie_write_profiler #(
        .BUF_AWIDTH (BUF_AWIDTH),
        .BUF_DEPTH  (BUF_DEPTH)
    ) pcie_write_profiler_i (
        .clk             (clk),
        .rst             (rst),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .wrdm_desc_ready (wrdm_desc_ready),
        .wrdm_desc_valid (wrdm_desc_valid),
        .wrdm_desc_data  (wrdm_desc_data),
        .frb_read        (frb_read),
        .frb_address     (frb_address),
        .frb_readvalid   (frb_readvalid),
        .frb_readdata    (frb_readdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_main = xorshift(rng_main);
        return rng_main;
    endfunction

    function automatic wrdm_desc_t data_desc(input logic [17:0] size, input logic [63:0] kmem);
        wrdm_desc_t d;
        d            = '0;
        d.nb_dwords  = size;
        d.dst_addr   = kmem + EXP_DATA_OFS;
        d.saddr_data = EXP_EP_BASE;
        return d;
    endfunction

    // immediate write of the running count to the buffer head
    function automatic wrdm_desc_t done_desc(input logic [63:0] kmem, input int count);
        wrdm_desc_t d;
        d            = '0;
        d.desc_id    = EXP_DONE_ID;
        d.immediate  = 1'b1;
        d.nb_dwords  = 18'd1;
        d.dst_addr   = kmem;
        d.saddr_data = 64'(count);
        return d;
    endfunction

    function automatic logic [511:0] pattern_word(input logic [BUF_AWIDTH-1:0] addr);
        logic [63:0] w;
        w = FILL_WORD;
        w[BUF_AWIDTH-1:0] = addr;
        return {8{w}};
    endfunction

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failing++;
            $display("test %s: FAIL with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check_value("pready", pready, 1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_idle();
        apb_data_t d;
        logic      err;
        d = 32'h1;
        while (d[0]) begin
            apb_read(REG_STATUS, d, err);
        end
    endtask

    task automatic test_registers();
        apb_data_t d;
        logic      err;
        apb_data_t v_target;
        apb_data_t v_size;
        apb_data_t v_lo;
        apb_data_t v_hi;
        apb_data_t v_ctrl;
        begin_test();
        v_target = next_rand();
        v_size   = next_rand();
        v_lo     = next_rand();
        v_hi     = next_rand();
        // start bit kept clear so no run begins
        v_ctrl   = next_rand() & 32'h6;
        apb_write(REG_TARGET, v_target, err);
        check_value("pslverr", err, 0);
        apb_write(REG_REQ_SIZE, v_size, err);
        apb_write(REG_KMEM_LO, v_lo, err);
        apb_write(REG_KMEM_HI, v_hi, err);
        apb_write(REG_CTRL, v_ctrl, err);
        apb_read(REG_TARGET, d, err);
        check_value("TARGET", d, v_target);
        check_value("pslverr", err, 0);
        apb_read(REG_REQ_SIZE, d, err);
        check_value("REQ_SIZE", d, v_size & 32'h3ffff);
        apb_read(REG_KMEM_LO, d, err);
        check_value("KMEM_LO", d, v_lo);
        apb_read(REG_KMEM_HI, d, err);
        check_value("KMEM_HI", d, v_hi);
        apb_read(REG_CTRL, d, err);
        check_value("CTRL", d, v_ctrl);
        apb_read(8'h24, d, err);
        check_value("pslverr", err, 1);
        apb_write(REG_STATUS, 32'h1, err);
        check_value("pslverr", err, 1);
        apb_write(REG_CTRL, 32'h0, err);
        end_test("registers");
    endtask

    // programs one run, builds the expected descriptor stream and waits for busy to fall
    task automatic do_run(input int target, input logic wp, input logic restart);
        logic [31:0] r;
        logic [17:0] size;
        logic [63:0] kmem;
        apb_data_t   d;
        logic        err;
        r       = next_rand();
        size    = r[17:0];
        r       = next_rand();
        kmem    = {r, 32'h0};
        r       = next_rand();
        kmem    = kmem | 64'(r);
        exp_q.delete();
        for (int i = 1; i <= target; i++) begin
            exp_q.push_back(data_desc(size, kmem));
            if (wp) begin
                exp_q.push_back(done_desc(kmem, i));
            end
        end
        exp_total = wp ? 2 * target : target;
        accepted  = 0;
        low_seen  = 0;
        apb_write(REG_TARGET, apb_data_t'(target), err);
        apb_write(REG_REQ_SIZE, apb_data_t'(size), err);
        apb_write(REG_KMEM_LO, kmem[31:0], err);
        apb_write(REG_KMEM_HI, kmem[63:32], err);
        apb_write(REG_CTRL, {29'd0, 1'b0, wp, 1'b1}, err);
        // the issuer leaves IDLE on this edge
        @(posedge clk);
        in_run = 1'b1;
        if (restart) begin
            apb_write(REG_CTRL, {29'd0, 1'b0, wp, 1'b1}, err);
        end
        wait_idle();
        in_run = 1'b0;
        check_value("accepted descriptors", accepted, exp_total);
        apb_read(REG_NB_REQ, d, err);
        check_value("NB_REQ", d, target);
    endtask

    task automatic read_burst(input logic bram);
        logic [31:0] r;
        logic        err;
        apb_write(REG_CTRL, {29'd0, bram, 2'b00}, err);
        rd_latency = bram ? 2 : 1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            frb_read    <= r[0];
            frb_address <= r[BUF_AWIDTH+7:8];
            @(posedge clk);
        end
        frb_read <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    // data mover ready drops low for 0 to 5 cycles between high runs
    always @(posedge clk) begin
        if (rst || !ready_random) begin
            wrdm_desc_ready <= 1'b1;
            lo_left = 0;
            hi_left = 0;
        end else begin
            if (lo_left == 0 && hi_left == 0) begin
                rng_ready = xorshift(rng_ready);
                lo_left   = int'(rng_ready % 6);
                hi_left   = 3 + int'((rng_ready >> 8) % 16);
            end
            if (lo_left != 0) begin
                wrdm_desc_ready <= 1'b0;
                lo_left = lo_left - 1;
            end else begin
                wrdm_desc_ready <= 1'b1;
                hi_left = hi_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            $display("timeout: no result within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    // mover model and read checker sample mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (wrdm_desc_valid && !wrdm_desc_ready) begin
                report_problem("descriptor valid while the mover was not ready");
            end
            // the issuer is surely outside IDLE until the second to last send
            if (in_run && !wrdm_desc_ready && (accepted + 1 < exp_total)) begin
                low_seen++;
            end
            if (wrdm_desc_valid) begin
                accepted++;
                if (exp_q.size() == 0) begin
                    report_problem("descriptor accepted when none was expected");
                end else begin
                    exp_d = exp_q.pop_front();
                    check_value("desc_id", wrdm_desc_data.desc_id, exp_d.desc_id);
                    check_value("immediate", wrdm_desc_data.immediate, exp_d.immediate);
                    check_value("nb_dwords", wrdm_desc_data.nb_dwords, exp_d.nb_dwords);
                    check_value("dst_addr", wrdm_desc_data.dst_addr, exp_d.dst_addr);
                    check_value("saddr_data", wrdm_desc_data.saddr_data, exp_d.saddr_data);
                end
            end
            if (frb_readvalid) begin
                if (rd_due.size() == 0 || rd_due[0] != cyc) begin
                    report_problem("read data returned with no read due in this cycle");
                end else begin
                    check_value("frb_readdata", frb_readdata, rd_data[0]);
                    void'(rd_due.pop_front());
                    void'(rd_data.pop_front());
                end
            end else if (rd_due.size() != 0 && rd_due[0] == cyc) begin
                report_problem("read data missing in the cycle it was due");
                void'(rd_due.pop_front());
                void'(rd_data.pop_front());
            end
            if (frb_read) begin
                rd_due.push_back(cyc + rd_latency);
                if (rd_latency == 2) begin
                    rd_data.push_back(pattern_word(frb_address));
                end else begin
                    rd_data.push_back({8{BYPASS_WORD}});
                end
            end
        end
    end

    initial begin
        apb_data_t d;
        logic      err;
        int        t_plain;
        int        t_ptr;
        int        t_bp;
        clk             = 1'b0;
        rst             = 1'b1;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        frb_read        = 1'b0;
        frb_address     = '0;
        rng_main        = 32'(SEED);
        rng_ready       = xorshift(32'(SEED));
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failing   = 0;
        cyc             = 0;
        ready_random    = 1'b0;
        lo_left         = 0;
        hi_left         = 0;
        in_run          = 1'b0;
        accepted        = 0;
        exp_total       = 0;
        low_seen        = 0;
        rd_latency      = 1;
        t_plain         = 4 + int'(next_rand() % 16);
        t_ptr           = 4 + int'(next_rand() % 16);
        t_bp            = 4 + int'(next_rand() % 16);
        cycle_limit     = 20 * (t_plain + t_ptr + t_bp + RESTART_TARGET) + 2000;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // pattern fill has to complete before any read
        repeat (BUF_DEPTH + 2) @(posedge clk);

        test_registers();

        begin_test();
        do_run(t_plain, 1'b0, 1'b0);
        end_test("data run");

        begin_test();
        do_run(t_ptr, 1'b1, 1'b0);
        end_test("pointer write-back");

        begin_test();
        ready_random <= 1'b1;
        do_run(t_bp, 1'b1, 1'b0);
        ready_random <= 1'b0;
        apb_read(REG_STALL_CNT, d, err);
        if (low_seen > 0) begin
            check_value("STALL_CNT nonzero", d != 0, 1);
        end
        apb_read(REG_TX_CYCLES, d, err);
        check_value("TX_CYCLES at least descriptors", d >= exp_total, 1);
        end_test("back-pressure");

        begin_test();
        read_burst(1'b1);
        read_burst(1'b0);
        end_test("read path");

        begin_test();
        do_run(RESTART_TARGET, 1'b0, 1'b1);
        exp_q.delete();
        exp_total = 0;
        accepted  = 0;
        apb_write(REG_TARGET, 32'h0, err);
        apb_write(REG_CTRL, 32'h1, err);
        repeat (3) @(posedge clk);
        apb_read(REG_STATUS, d, err);
        check_value("STATUS busy", d[0], 0);
        check_value("accepted descriptors", accepted, 0);
        end_test("start rules");

        $display("summary: %0d tests, %0d failing, %0d errors", tests_run, tests_failing, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/pcie_desc_pkg.sv
rtl/prof_regs_pkg.sv
rtl/prof_apb_regs.sv
rtl/desc_issuer.sv
rtl/pattern_buffer.sv
rtl/pcie_write_profiler.sv
test/tb_pcie_write_profiler.sv

// ==== Makefile ====
# Verilator build and run of the PCIe write profiler testbench

VERILATOR ?= verilator
TOP       ?= tb_pcie_write_profiler
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^all tests passed$$' $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
